//--- Makefile
TOP = rv64_core_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f rv64_core.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir

//--- design/rv64_alu.sv
`timescale 1ns/1ps

module rv64_alu
    import rv64_isa_pkg::*;
    import rv64_ctrl_pkg::*;
(
    input  xlen_t   a,
    input  xlen_t   b,
    input  alu_op_e op,
    output xlen_t   result,
    output logic    zero,
    output logic    negative,
    output logic    carry,
    output logic    overflow
);

    xlen_t      diff;
    logic [5:0] shamt;

    // Flags always from a - b, carry set when a >= b unsigned
    assign {carry, diff} = {1'b0, a} + {1'b0, ~b} + 65'd1;
    assign zero          = diff == '0;
    assign negative      = diff[63];
    assign overflow      = (a[63] ^ b[63]) & (a[63] ^ diff[63]);
    assign shamt         = b[5:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = diff;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {63'd0, negative ^ overflow};
            ALU_SLTU: result = {63'd0, ~carry};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = xlen_t'($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

//--- design/rv64_control_unit.sv
`timescale 1ns/1ps

module rv64_control_unit
    import rv64_isa_pkg::*;
    import rv64_ctrl_pkg::*;
(
    input  logic       clock,
    input  logic       arst_n,
    input  dp_status_t status,
    input  logic       imem_valid,
    input  logic       dmem_valid,
    output ctrl_word_t ctrl,
    output logic       imem_req,
    output logic       dmem_req,
    output logic       retire
);

    typedef enum logic [2:0] {FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK} state_e;

    state_e        state;
    state_e        state_next;
    instr_fields_t f;
    ctrl_word_t    dec;
    logic          is_branch;
    logic          is_jump;
    logic          cond;
    logic          take_q;
    logic          pending;

    function automatic alu_op_e alu_decode(logic [2:0] funct3, logic alt);
        case (funct3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign f = status.fields;

    // Decode of the held instruction
    always_comb begin
        dec = '0;
        dec.alu_b_sel = B_IMM;
        is_branch = 1'b0;
        is_jump = 1'b0;
        case (f.opcode)
            OPC_OP: begin
                dec.alu_b_sel = B_REG;
                dec.alu_op    = alu_decode(f.funct3, f.funct7_b30);
                dec.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                // ADDI ignores bit 30
                dec.alu_op    = alu_decode(f.funct3, f.funct7_b30 && f.funct3 == F3_SR);
                dec.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                dec.wb_sel       = WB_LOAD;
                dec.mem_size     = mem_size_e'(f.funct3[1:0]);
                dec.mem_unsigned = f.funct3[2];
                dec.reg_write    = 1'b1;
            end
            OPC_STORE: begin
                dec.mem_size = mem_size_e'(f.funct3[1:0]);
            end
            OPC_BRANCH: begin
                dec.alu_a_sel = A_PC;
                is_branch     = 1'b1;
            end
            OPC_JAL: begin
                dec.alu_a_sel = A_PC;
                dec.wb_sel    = WB_PC4;
                dec.reg_write = 1'b1;
                is_jump       = 1'b1;
            end
            OPC_JALR: begin
                dec.wb_sel    = WB_PC4;
                dec.reg_write = 1'b1;
                is_jump       = 1'b1;
            end
            OPC_LUI: begin
                dec.wb_sel    = WB_IMM;
                dec.reg_write = 1'b1;
            end
            OPC_AUIPC: begin
                dec.alu_a_sel = A_PC;
                dec.reg_write = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        ctrl = dec;
        ctrl.reg_write = dec.reg_write && state == WRITEBACK;
        ctrl.pc_enable = state == WRITEBACK;
        ctrl.pc_load   = state == WRITEBACK && (is_jump || take_q);
        ctrl.ir_load   = state == FETCH && imem_valid;
        ctrl.opnd_load = state == DECODE;
        ctrl.data_load = state == MEMORY && dmem_valid;
        // Branches compare rs1 and rs2 here, the target is formed in writeback
        if (is_branch && state == EXECUTE) begin
            ctrl.alu_a_sel = A_REG;
            ctrl.alu_b_sel = B_REG;
        end
    end

    always_comb begin
        case (f.funct3)
            F3_BEQ, F3_BNE:   cond = status.zero;
            F3_BLT, F3_BGE:   cond = status.negative ^ status.overflow;
            F3_BLTU, F3_BGEU: cond = !status.carry;
            default:          cond = 1'b0;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            FETCH:   if (imem_valid) state_next = DECODE;
            DECODE:  state_next = EXECUTE;
            EXECUTE: begin
                if (f.opcode == OPC_LOAD || f.opcode == OPC_STORE) begin
                    state_next = MEMORY;
                end else begin
                    state_next = WRITEBACK;
                end
            end
            MEMORY:  if (dmem_valid) state_next = WRITEBACK;
            default: state_next = FETCH;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state    <= FETCH;
            pending  <= 1'b0;
            imem_req <= 1'b0;
            dmem_req <= 1'b0;
            take_q   <= 1'b0;
        end else begin
            state    <= state_next;
            pending  <= (pending || imem_req || dmem_req) && !(imem_valid || dmem_valid);
            // Strobes are single cycle on entry to FETCH or MEMORY
            imem_req <= state_next == FETCH && !pending && !imem_req;
            dmem_req <= state_next == MEMORY && state != MEMORY;
            if (state == EXECUTE) begin
                take_q <= is_branch && (cond ^ f.funct3[0]);
            end
        end
    end

    assign retire = state == WRITEBACK;

    assert property (@(posedge clock) disable iff (!arst_n)
        !(imem_req && dmem_req));

    // Nothing new goes out until the response arrives
    assert property (@(posedge clock) disable iff (!arst_n)
        pending |-> !imem_req && !dmem_req);

endmodule

//--- design/rv64_core.sv
`timescale 1ns/1ps

module rv64_core
    import rv64_isa_pkg::*;
    import rv64_ctrl_pkg::*;
#(
    parameter xlen_t RESET_PC = 64'h0
) (
    input  logic        clock,
    input  logic        arst_n,
    output logic        imem_req,
    output xlen_t       imem_addr,
    input  logic        imem_valid,
    input  logic [31:0] imem_data,
    output logic        dmem_req,
    output mem_req_t    dmem_req_info,
    input  logic        dmem_valid,
    input  xlen_t       dmem_rdata,
    output logic        retire,
    output retire_t     retire_info
);

    ctrl_word_t ctrl;
    dp_status_t status;

    rv64_control_unit control_unit_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .status     (status),
        .imem_valid (imem_valid),
        .dmem_valid (dmem_valid),
        .ctrl       (ctrl),
        .imem_req   (imem_req),
        .dmem_req   (dmem_req),
        .retire     (retire)
    );

    rv64_dataflow #(
        .RESET_PC (RESET_PC)
    ) dataflow_i (
        .clock         (clock),
        .arst_n        (arst_n),
        .ctrl          (ctrl),
        .imem_data     (imem_data),
        .dmem_rdata    (dmem_rdata),
        .status        (status),
        .imem_addr     (imem_addr),
        .dmem_req_info (dmem_req_info),
        .retire_info   (retire_info)
    );

endmodule

//--- design/rv64_ctrl_pkg.sv
package rv64_ctrl_pkg;

    import rv64_isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic {A_REG, A_PC} alu_a_sel_e;
    typedef enum logic {B_REG, B_IMM} alu_b_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4, WB_IMM} wb_sel_e;

    // Encoded as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {MEM_B, MEM_H, MEM_W, MEM_D} mem_size_e;

    typedef struct packed {
        alu_op_e    alu_op;
        alu_a_sel_e alu_a_sel;
        alu_b_sel_e alu_b_sel;
        wb_sel_e    wb_sel;
        logic       reg_write;
        mem_size_e  mem_size;
        logic       mem_unsigned;
        // Next PC from the ALU sum
        logic       pc_load;
        logic       pc_enable;
        logic       ir_load;
        logic       opnd_load;
        logic       data_load;
    } ctrl_word_t;

    typedef struct packed {
        instr_fields_t fields;
        logic          zero;
        logic          negative;
        logic          carry;
        logic          overflow;
    } dp_status_t;

    typedef struct packed {
        xlen_t      pc;
        logic [4:0] rd;
        logic       wen;
        xlen_t      value;
    } retire_t;

    typedef struct packed {
        logic       we;
        xlen_t      addr;
        xlen_t      wdata;
        logic [7:0] byte_en;
    } mem_req_t;

endpackage

//--- design/rv64_dataflow.sv
`timescale 1ns/1ps

module rv64_dataflow
    import rv64_isa_pkg::*;
    import rv64_ctrl_pkg::*;
#(
    parameter xlen_t RESET_PC = '0
) (
    input  logic        clock,
    input  logic        arst_n,
    input  ctrl_word_t  ctrl,
    input  logic [31:0] imem_data,
    input  xlen_t       dmem_rdata,
    output dp_status_t  status,
    output xlen_t       imem_addr,
    output mem_req_t    dmem_req_info,
    output retire_t     retire_info
);

    xlen_t         pc_q;
    logic [31:0]   ir_q;
    xlen_t         a_q;
    xlen_t         b_q;
    xlen_t         result_q;
    xlen_t         load_q;
    xlen_t         rdata1;
    xlen_t         rdata2;
    xlen_t         imm;
    xlen_t         alu_a;
    xlen_t         alu_b;
    xlen_t         alu_result;
    xlen_t         load_data;
    xlen_t         store_wdata;
    xlen_t         pc_plus4;
    xlen_t         wb_data;
    logic [7:0]    byte_en;
    instr_fields_t fields;
    logic          zero;
    logic          negative;
    logic          carry;
    logic          overflow;
    logic [2:0]    align_mask;

    assign fields = {ir_q[6:0], ir_q[11:7], ir_q[14:12], ir_q[19:15], ir_q[24:20], ir_q[30]};

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= RESET_PC;
            ir_q <= '0;
        end else begin
            if (ctrl.pc_enable) begin
                // Bit 0 cleared for JALR, already zero for other targets
                pc_q <= ctrl.pc_load ? {alu_result[63:1], 1'b0} : pc_plus4;
            end
            if (ctrl.ir_load) begin
                ir_q <= imem_data;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.opnd_load) begin
            a_q <= rdata1;
            b_q <= rdata2;
        end
        if (ctrl.data_load) begin
            load_q <= load_data;
        end
        result_q <= alu_result;
    end

    assign alu_a    = (ctrl.alu_a_sel == A_PC) ? pc_q : a_q;
    assign alu_b    = (ctrl.alu_b_sel == B_IMM) ? imm : b_q;
    assign pc_plus4 = pc_q + 64'd4;

    always_comb begin
        case (ctrl.wb_sel)
            WB_ALU:  wb_data = result_q;
            WB_LOAD: wb_data = load_q;
            WB_PC4:  wb_data = pc_plus4;
            default: wb_data = imm;
        endcase
    end

    rv64_register_file register_file_i (
        .clock  (clock),
        .arst_n (arst_n),
        .rs1    (fields.rs1),
        .rs2    (fields.rs2),
        .rd     (fields.rd),
        .wen    (ctrl.reg_write),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    rv64_immediate_extender immediate_extender_i (
        .instr (ir_q),
        .imm   (imm)
    );

    rv64_alu alu_i (
        .a        (alu_a),
        .b        (alu_b),
        .op       (ctrl.alu_op),
        .result   (alu_result),
        .zero     (zero),
        .negative (negative),
        .carry    (carry),
        .overflow (overflow)
    );

    rv64_mem_lane mem_lane_i (
        .addr          (result_q),
        .size          (ctrl.mem_size),
        .unsigned_load (ctrl.mem_unsigned),
        .store_data    (b_q),
        .raw_load      (dmem_rdata),
        .byte_en       (byte_en),
        .wdata         (store_wdata),
        .load_data     (load_data)
    );

    assign status = '{
        fields:   fields,
        zero:     zero,
        negative: negative,
        carry:    carry,
        overflow: overflow
    };

    assign imem_addr = pc_q;

    assign dmem_req_info = '{
        we:      fields.opcode == OPC_STORE,
        addr:    result_q,
        wdata:   store_wdata,
        byte_en: byte_en
    };

    // x0 writes retire with a zero value
    assign retire_info = '{
        pc:    pc_q,
        rd:    fields.rd,
        wen:   ctrl.reg_write,
        value: (ctrl.reg_write && fields.rd != 5'd0) ? wb_data : '0
    };

    assign align_mask = {ctrl.mem_size == MEM_D, ctrl.mem_size inside {MEM_W, MEM_D},
                         ctrl.mem_size != MEM_B};

    assert property (@(posedge clock) disable iff (!arst_n)
        ctrl.pc_enable |=> pc_q[1:0] == 2'b00);

    // Natural alignment of every completed data access
    assert property (@(posedge clock) disable iff (!arst_n)
        ctrl.data_load |-> (result_q[2:0] & align_mask) == 3'b000);

endmodule

//--- design/rv64_immediate_extender.sv
`timescale 1ns/1ps

module rv64_immediate_extender
    import rv64_isa_pkg::*;
(
    input  logic [31:0] instr,
    output xlen_t       imm
);

    opcode_e opcode;

    assign opcode = opcode_e'(instr[6:0]);

    always_comb begin
        case (opcode)
            OPC_LOAD, OPC_OP_IMM, OPC_JALR:
                imm = {{52{instr[31]}}, instr[31:20]};
            OPC_STORE:
                imm = {{52{instr[31]}}, instr[31:25], instr[11:7]};
            OPC_BRANCH:
                imm = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:
                imm = {{32{instr[31]}}, instr[31:12], 12'd0};
            OPC_JAL:
                imm = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

//--- design/rv64_isa_pkg.sv
package rv64_isa_pkg;

    typedef logic [63:0] xlen_t;

    // Major opcodes of the supported RV64I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    // ALU funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Fields cut from a 32-bit instruction
    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rd;
        logic [2:0] funct3;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic       funct7_b30;
    } instr_fields_t;

endpackage

//--- design/rv64_mem_lane.sv
`timescale 1ns/1ps

module rv64_mem_lane
    import rv64_isa_pkg::*;
    import rv64_ctrl_pkg::*;
(
    input  xlen_t      addr,
    input  mem_size_e  size,
    input  logic       unsigned_load,
    input  xlen_t      store_data,
    input  xlen_t      raw_load,
    output logic [7:0] byte_en,
    output xlen_t      wdata,
    output xlen_t      load_data
);

    logic [2:0] offset;
    logic [7:0] size_mask;
    xlen_t      shifted;

    // Byte lane within the 64-bit word
    assign offset  = addr[2:0];
    assign wdata   = store_data << {offset, 3'b000};
    assign byte_en = size_mask << offset;
    assign shifted = raw_load >> {offset, 3'b000};

    always_comb begin
        case (size)
            MEM_B: begin
                size_mask = 8'h01;
                load_data = {{56{shifted[7] & ~unsigned_load}}, shifted[7:0]};
            end
            MEM_H: begin
                size_mask = 8'h03;
                load_data = {{48{shifted[15] & ~unsigned_load}}, shifted[15:0]};
            end
            MEM_W: begin
                size_mask = 8'h0f;
                load_data = {{32{shifted[31] & ~unsigned_load}}, shifted[31:0]};
            end
            default: begin
                size_mask = 8'hff;
                load_data = shifted;
            end
        endcase
    end

endmodule

//--- design/rv64_register_file.sv
`timescale 1ns/1ps

module rv64_register_file
    import rv64_isa_pkg::*;
(
    input  logic       clock,
    input  logic       arst_n,
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  logic [4:0] rd,
    input  logic       wen,
    input  xlen_t      wdata,
    output xlen_t      rdata1,
    output xlen_t      rdata2
);

    xlen_t regs [32];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    assert property (@(posedge clock) disable iff (!arst_n)
        rs1 == 5'd0 |-> rdata1 == '0);

endmodule

//--- rv64_core.f
design/rv64_isa_pkg.sv
design/rv64_ctrl_pkg.sv
design/rv64_alu.sv
design/rv64_register_file.sv
design/rv64_immediate_extender.sv
design/rv64_mem_lane.sv
design/rv64_control_unit.sv
design/rv64_dataflow.sv
design/rv64_core.sv
test/rv64_core_tb.sv

//--- test/rv64_core_stimulus.mem
// Counts: program words, data words, retire records
// Then program words, data words, and records of pc, rd*16+wen, value
3B 4 31
FFB00093 00300113 002081B3 40110233 0020A2B3 0020B333 002093B3 0020D433
4020D4B3 0020C533 0020E5B3 0020F633 FFF13693 FFF12713 4010D793 03E11813
03C85893 07F0C913 10016993 0F00FA13 00708013 80000AB7 00001B17 00103823
002008A3 00C01B23 01502C23 01003B83 00000C03 00104C83 00201D03 00605D83
00402E03 01806E83 00C10463 00100F13 00208463 00209463 00100F13 00C11463
0020C463 00100F13 00114463 00115463 00100F13 0020D463 00116463 00100F13
0020E463 0020F463 00100F13 00117463 00C00FEF 00100F13 00100F13 015F82E7
00100F13 00100F13 00128313
F0E1D2C3B4A59687 0123456789ABCDEF AAAAAAAAAAAAAAAA 1111111122222222
100 11 FFFFFFFFFFFFFFFB
104 21 3
108 31 FFFFFFFFFFFFFFFE
10C 41 8
110 51 1
114 61 0
118 71 FFFFFFFFFFFFFFD8
11C 81 1FFFFFFFFFFFFFFF
120 91 FFFFFFFFFFFFFFFF
124 A1 FFFFFFFFFFFFFFF8
128 B1 FFFFFFFFFFFFFFFB
12C C1 3
130 D1 1
134 E1 0
138 F1 FFFFFFFFFFFFFFFD
13C 101 C000000000000000
140 111 C
144 121 FFFFFFFFFFFFFF84
148 131 103
14C 141 F0
150 01 0
154 151 FFFFFFFF80000000
158 161 1158
15C 00 0
160 00 0
164 00 0
168 00 0
16C 171 0003FFFFFFFF03FB
170 181 FFFFFFFFFFFFFF87
174 191 96
178 1A1 FFFFFFFFFFFFB4A5
17C 1B1 F0E1
180 1C1 FFFFFFFFF0E1D2C3
184 1D1 80000000
188 00 0
190 00 0
194 00 0
19C 00 0
1A0 00 0
1A8 00 0
1AC 00 0
1B4 00 0
1B8 00 0
1C0 00 0
1C4 00 0
1CC 00 0
1D0 1F1 1D4
1DC 51 1E0
1E8 61 1E1

//--- test/rv64_core_tb.sv
`timescale 1ns/1ps

module rv64_core_tb
    import rv64_isa_pkg::*;
    import rv64_ctrl_pkg::*;
;

    localparam xlen_t RESET_PC = 64'h100;
    localparam int FIRST_FETCH_DELAY = 10;

    logic        clock;
    logic        arst_n;
    logic        imem_req;
    xlen_t       imem_addr;
    logic        imem_valid;
    logic [31:0] imem_data;
    logic        dmem_req;
    mem_req_t    dmem_req_info;
    logic        dmem_valid;
    xlen_t       dmem_rdata;
    logic        retire;
    retire_t     retire_info;

    xlen_t       stim [0:255];
    logic [31:0] imem [0:63];
    xlen_t       dmem [0:3];
    int          n_instr;
    int          n_data;
    int          n_rec;
    int          rec_idx;
    int          cycle;
    int          limit;
    int          seed;
    int          valid_cycle;
    int          data_valid_cycle;
    logic [6:0]  last_opcode;

    rv64_core #(
        .RESET_PC (RESET_PC)
    ) dut_i (
        .clock         (clock),
        .arst_n        (arst_n),
        .imem_req      (imem_req),
        .imem_addr     (imem_addr),
        .imem_valid    (imem_valid),
        .imem_data     (imem_data),
        .dmem_req      (dmem_req),
        .dmem_req_info (dmem_req_info),
        .dmem_valid    (dmem_valid),
        .dmem_rdata    (dmem_rdata),
        .retire        (retire),
        .retire_info   (retire_info)
    );

    task automatic check_value(input xlen_t actual, input xlen_t expected, input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic report_failure(input string why);
        $display("Error at %0t ns: %s", $time, why);
        $display("Test failed");
        $fatal(1);
    endtask

    // Past the program the core only sees NOPs
    function automatic logic [31:0] fetch_word(input xlen_t addr);
        xlen_t index;
        index = (addr - RESET_PC) >> 2;
        if (addr < RESET_PC || index >= xlen_t'(n_instr)) begin
            return 32'h0000_0013;
        end
        return imem[index[5:0]];
    endfunction

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        seed = 59584;
        cycle = 0;
        rec_idx = 0;
        valid_cycle = 0;
        data_valid_cycle = 0;
        last_opcode = '0;
        arst_n = 1'b0;
        imem_valid = 1'b0;
        imem_data = '0;
        dmem_valid = 1'b0;
        dmem_rdata = '0;
        $readmemh("test/rv64_core_stimulus.mem", stim);
        n_instr = int'(stim[0]);
        n_data = int'(stim[1]);
        n_rec = int'(stim[2]);
        for (int i = 0; i < n_instr; i++) begin
            imem[i] = stim[3 + i][31:0];
        end
        for (int i = 0; i < n_data; i++) begin
            dmem[i] = stim[3 + n_instr + i];
        end
        limit = n_rec * 16 + 50;
        repeat (3) begin
            @(posedge clock);
            check_value(xlen_t'({imem_req, dmem_req, retire}), '0, "strobes in reset");
        end
        arst_n <= 1'b1;
    end

    // Instruction memory holds back its first answer to watch the idle core
    initial begin : fetch_model
        xlen_t       addr;
        int          wait_cycles;
        logic        first;
        logic [31:0] word;
        first = 1'b1;
        forever begin
            @(posedge clock);
            if (arst_n && imem_req) begin
                addr = imem_addr;
                if (first) begin
                    check_value(addr, RESET_PC, "first fetch address");
                    wait_cycles = FIRST_FETCH_DELAY;
                    first = 1'b0;
                end else begin
                    wait_cycles = 1 + int'($unsigned($random(seed)) % 4);
                end
                repeat (wait_cycles - 1) begin
                    @(posedge clock);
                    if (imem_req || dmem_req || retire) begin
                        report_failure("core active while waiting for an instruction");
                    end
                end
                word = fetch_word(addr);
                imem_valid <= 1'b1;
                imem_data <= word;
                @(posedge clock);
                imem_valid <= 1'b0;
                valid_cycle = cycle;
                last_opcode = word[6:0];
            end
        end
    end

    initial begin : data_model
        mem_req_t req;
        int       wait_cycles;
        forever begin
            @(posedge clock);
            if (arst_n && dmem_req) begin
                req = dmem_req_info;
                if (req.addr >= 64'd32) begin
                    report_failure("data access outside the data memory");
                end
                if (req.we) begin
                    for (int b = 0; b < 8; b++) begin
                        if (req.byte_en[b]) begin
                            dmem[req.addr[4:3]][8*b +: 8] = req.wdata[8*b +: 8];
                        end
                    end
                end
                wait_cycles = 1 + int'($unsigned($random(seed)) % 4);
                repeat (wait_cycles - 1) begin
                    @(posedge clock);
                    if (imem_req || dmem_req) begin
                        report_failure("new request while a data access is pending");
                    end
                end
                dmem_valid <= 1'b1;
                dmem_rdata <= dmem[req.addr[4:3]];
                @(posedge clock);
                dmem_valid <= 1'b0;
                data_valid_cycle = cycle;
            end
        end
    end

    // Record layout is pc, rd and wen as rd*16+wen, value
    task automatic check_retire();
        int    base;
        xlen_t rdwen;
        base = 3 + n_instr + n_data + 3 * rec_idx;
        rdwen = stim[base + 1];
        check_value(retire_info.pc, stim[base], "retire pc");
        check_value(xlen_t'(retire_info.wen), xlen_t'(rdwen[0]), "retire wen");
        if (rdwen[0]) begin
            check_value(xlen_t'(retire_info.rd), xlen_t'(rdwen[8:4]), "retire rd");
        end
        check_value(retire_info.value, stim[base + 2], "retire value");
        if (last_opcode != OPC_LOAD && last_opcode != OPC_STORE) begin
            check_value(xlen_t'(cycle - valid_cycle), 64'd3, "cycles from fetch to retire");
        end else begin
            check_value(xlen_t'(cycle - data_valid_cycle), 64'd1,
                        "cycles from data response to retire");
        end
        rec_idx++;
        if (rec_idx == n_rec) begin
            $display("Test passed");
            $finish;
        end
    endtask

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle == limit) begin
            report_failure("timeout, the core stopped retiring instructions");
        end
        if (arst_n && retire) begin
            check_retire();
        end
    end

endmodule
